//--- Bender.yml
package:
  name: cp0

export_include_dirs:
  - common

sources:
  - files:
      - common/cp0Pkg.sv
      - src/cp0AccessPort.sv
      - src/cp0Timer.sv
      - src/cp0ExceptionUnit.sv
      - src/cp0Top.sv
  - target: simulation
    files:
      - verif/cp0ClockGen.sv
      - verif/cp0Checker.sv
      - verif/cp0_assert.sv
      - verif/cp0Tb.sv

//--- common/cp0Pkg.sv
// CP0 shared types
// register numbers, exception codes and the exception flag set
// that the write-back stage hands to the CP0 block

`include "cp0_config.svh"

package cp0Pkg;

    // register numbers implemented by this block
    typedef enum logic [`CP0_ADDR_W-1:0] {
        regBadVAddr = 5'd8,
        regCount    = 5'd9,
        regCompare  = 5'd11,
        regStatus   = 5'd12,
        regCause    = 5'd13,
        regEpc      = 5'd14
    } cp0RegAddrT;

    // Cause.ExcCode values
    typedef enum logic [4:0] {
        excInt  = 5'd0,
        excAdEL = 5'd4,     // fetch or load address error
        excAdES = 5'd5,     // store address error
        excSys  = 5'd8,
        excBp   = 5'd9,
        excRI   = 5'd10,
        excOv   = 5'd12
    } excCodeT;

    // one flag per event, highest priority first
    typedef struct packed {
        logic interrupt;
        logic fetchAddrErr;
        logic reservedInstr;
        logic syscall;
        logic breakpoint;
        logic eret;
        logic overflow;
        logic storeAddrErr;
        logic loadAddrErr;
    } exceptFlagsT;

endpackage

//--- common/cp0_config.svh
// CP0 register block configuration
// widths, reset value, write masks and the register field positions
// shared by the CP0 RTL and its checker

`ifndef CP0_CONFIG_SVH
`define CP0_CONFIG_SVH

// ************************************************************
// widths
`define CP0_DATA_W          32
`define CP0_ADDR_W          5
`define CP0_HWINT_N         6                   // external interrupt lines

// ************************************************************
// reset value and writable bits
`define CP0_STATUS_RESET    32'h0040_0000       // BEV only
`define CP0_STATUS_WMASK    32'h0000_ff03       // IM, EXL, IE
`define CP0_CAUSE_WMASK     32'h0000_0300       // software IP[1:0]

// ************************************************************
// field positions
`define CP0_STATUS_EXL      1
`define CP0_CAUSE_BD        31
`define CP0_CAUSE_TI        30
`define CP0_CAUSE_IP_LO     10                  // hw IP field starts here
`define CP0_CAUSE_EXC_LO    2                   // ExcCode field starts here

`endif

//--- sources.f
+incdir+common
common/cp0Pkg.sv
src/cp0AccessPort.sv
src/cp0Timer.sv
src/cp0ExceptionUnit.sv
src/cp0Top.sv
verif/cp0ClockGen.sv
verif/cp0Checker.sv
verif/cp0_assert.sv
verif/cp0Tb.sv

//--- src/cp0AccessPort.sv
// CP0 access port
// decodes a write-back register write into per-register strobes,
// builds the forwarded register views and selects the read data

`include "cp0_config.svh"

module cp0AccessPort (
    input  logic                    wrEn,
    input  cp0Pkg::cp0RegAddrT      wrAddr,
    input  logic [`CP0_DATA_W-1:0]  wrData,
    input  cp0Pkg::cp0RegAddrT      rdAddr,
    input  logic [`CP0_DATA_W-1:0]  count,
    input  logic [`CP0_DATA_W-1:0]  compare,
    input  logic [`CP0_DATA_W-1:0]  status,
    input  logic [`CP0_DATA_W-1:0]  cause,
    input  logic [`CP0_DATA_W-1:0]  epc,
    input  logic [`CP0_DATA_W-1:0]  badVAddr,
    output logic                    countWr,
    output logic                    compareWr,
    output logic                    statusWr,
    output logic                    causeWr,
    output logic                    epcWr,
    output logic [`CP0_DATA_W-1:0]  rdData,
    output logic [`CP0_DATA_W-1:0]  statusFwd,
    output logic [`CP0_DATA_W-1:0]  causeFwd,
    output logic [`CP0_DATA_W-1:0]  epcFwd
);
    import cp0Pkg::*;

    logic [`CP0_DATA_W-1:0] countFwd;
    logic [`CP0_DATA_W-1:0] compareFwd;

    // ************************************************************
    // write decode, BadVAddr has no strobe
    assign countWr   = wrEn && (wrAddr == regCount);
    assign compareWr = wrEn && (wrAddr == regCompare);
    assign statusWr  = wrEn && (wrAddr == regStatus);
    assign causeWr   = wrEn && (wrAddr == regCause);
    assign epcWr     = wrEn && (wrAddr == regEpc);

    // ************************************************************
    // bypass of a write in flight, merged through the write masks
    assign countFwd   = countWr ? wrData : count;
    assign compareFwd = compareWr ? wrData : compare;
    assign epcFwd     = epcWr ? wrData : epc;

    assign statusFwd = statusWr ?
        ((wrData & `CP0_STATUS_WMASK) | (status & ~`CP0_STATUS_WMASK)) : status;
    assign causeFwd  = causeWr ?
        ((wrData & `CP0_CAUSE_WMASK) | (cause & ~`CP0_CAUSE_WMASK)) : cause;

    // read select
    always_comb begin
        case (rdAddr)
            regCount:    rdData = countFwd;
            regCompare:  rdData = compareFwd;
            regStatus:   rdData = statusFwd;
            regCause:    rdData = causeFwd;
            regEpc:      rdData = epcFwd;
            regBadVAddr: rdData = badVAddr;
            default:     rdData = '0;       // unimplemented reads as zero
        endcase
    end

endmodule

//--- src/cp0ExceptionUnit.sv
// CP0 exception unit
// holds Status, Cause, EPC and BadVAddr, samples the interrupt lines,
// applies masked register writes, and performs prioritised exception
// entry and eret

`include "cp0_config.svh"

module cp0ExceptionUnit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    statusWr,
    input  logic                    causeWr,
    input  logic                    epcWr,
    input  logic [`CP0_DATA_W-1:0]  wrData,
    input  logic [`CP0_HWINT_N-1:0] hwInt,
    input  logic                    timerIrq,
    input  cp0Pkg::exceptFlagsT     except,
    input  logic [`CP0_DATA_W-1:0]  pc,
    input  logic [`CP0_DATA_W-1:0]  aluOut,
    input  logic                    inDelaySlot,
    output logic [`CP0_DATA_W-1:0]  status,
    output logic [`CP0_DATA_W-1:0]  cause,
    output logic [`CP0_DATA_W-1:0]  epc,
    output logic [`CP0_DATA_W-1:0]  badVAddr
);
    import cp0Pkg::*;

    logic [`CP0_DATA_W-1:0]  causeQ;    // stored Cause, TI is live
    logic [`CP0_HWINT_N-1:0] ipVec;
    logic                    takeExc;
    logic                    doEret;
    logic                    loadBad;
    excCodeT                 excCode;
    logic [`CP0_DATA_W-1:0]  badAddr;

    // timer shares the top hardware line
    assign ipVec = {hwInt[`CP0_HWINT_N-1] | timerIrq, hwInt[`CP0_HWINT_N-2:0]};

    always_comb begin
        cause                = causeQ;
        cause[`CP0_CAUSE_TI] = timerIrq;
    end

    // ************************************************************
    // priority select, first set flag wins
    always_comb begin
        takeExc = 1'b1;
        doEret  = 1'b0;
        loadBad = 1'b0;
        excCode = excInt;
        badAddr = aluOut;
        if (except.interrupt) begin
            excCode = excInt;
        end else if (except.fetchAddrErr) begin
            excCode = excAdEL;
            loadBad = 1'b1;
            badAddr = pc;               // faulting fetch address
        end else if (except.reservedInstr) begin
            excCode = excRI;
        end else if (except.syscall) begin
            excCode = excSys;
        end else if (except.breakpoint) begin
            excCode = excBp;
        end else if (except.eret) begin
            takeExc = 1'b0;
            doEret  = 1'b1;
        end else if (except.overflow) begin
            excCode = excOv;
        end else if (except.storeAddrErr) begin
            excCode = excAdES;
            loadBad = 1'b1;
        end else if (except.loadAddrErr) begin
            excCode = excAdEL;
            loadBad = 1'b1;
        end else begin
            takeExc = 1'b0;
        end
    end

    // ************************************************************
    // register update, exception entry overrides a same-cycle write
    always_ff @(posedge clk) begin
        if (rst) begin
            status   <= `CP0_STATUS_RESET;
            causeQ   <= '0;
            epc      <= '0;
            badVAddr <= '0;
        end else begin
            if (statusWr) begin
                status <= (wrData & `CP0_STATUS_WMASK) | (status & ~`CP0_STATUS_WMASK);
            end
            if (causeWr) begin
                causeQ <= (wrData & `CP0_CAUSE_WMASK) | (causeQ & ~`CP0_CAUSE_WMASK);
            end
            causeQ[`CP0_CAUSE_IP_LO +: `CP0_HWINT_N] <= ipVec;  // pending lines
            if (epcWr) begin
                epc <= wrData;
            end

            if (takeExc) begin
                status[`CP0_STATUS_EXL]                <= 1'b1;
                causeQ[`CP0_CAUSE_EXC_LO +: $bits(excCodeT)] <= excCode;
                // nested exception keeps the first EPC and BD
                if (!status[`CP0_STATUS_EXL]) begin
                    epc                  <= inDelaySlot ? pc - 32'd4 : pc;
                    causeQ[`CP0_CAUSE_BD] <= inDelaySlot;
                end
                if (loadBad) begin
                    badVAddr <= badAddr;
                end
            end else if (doEret) begin
                status[`CP0_STATUS_EXL] <= 1'b0;
            end
        end
    end

endmodule

//--- src/cp0Timer.sv
// CP0 timer
// Count advancing every second cycle, Compare, and the sticky
// timer interrupt raised when Count reaches a nonzero Compare

`include "cp0_config.svh"

module cp0Timer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    countWr,
    input  logic                    compareWr,
    input  logic [`CP0_DATA_W-1:0]  wrData,
    output logic [`CP0_DATA_W-1:0]  count,
    output logic [`CP0_DATA_W-1:0]  compare,
    output logic                    timerIrq
);

    logic phase;                // count enable on odd cycles
    logic hit;

    assign hit = (compare != '0) && (count == compare);

    always_ff @(posedge clk) begin
        if (rst) begin
            count    <= '0;
            compare  <= '0;
            phase    <= 1'b0;
            timerIrq <= 1'b0;
        end else begin
            // a Count write restarts the divide-by-two
            if (countWr) begin
                count <= wrData;
                phase <= 1'b0;
            end else begin
                phase <= ~phase;
                if (phase) begin
                    count <= count + 1'b1;
                end
            end

            if (compareWr) begin
                compare  <= wrData;
                timerIrq <= 1'b0;       // writing Compare acknowledges
            end else if (hit) begin
                timerIrq <= 1'b1;
            end
        end
    end

endmodule

//--- src/cp0Top.sv
// CP0 register block top level
// connects the access port, the timer and the exception unit

`include "cp0_config.svh"

module cp0Top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wrEn,
    input  cp0Pkg::cp0RegAddrT      wrAddr,
    input  logic [`CP0_DATA_W-1:0]  wrData,
    input  cp0Pkg::cp0RegAddrT      rdAddr,
    output logic [`CP0_DATA_W-1:0]  rdData,
    input  logic [`CP0_HWINT_N-1:0] hwInt,
    input  cp0Pkg::exceptFlagsT     except,
    input  logic [`CP0_DATA_W-1:0]  pc,
    input  logic [`CP0_DATA_W-1:0]  aluOut,
    input  logic                    inDelaySlot,
    output logic [`CP0_DATA_W-1:0]  statusOut,
    output logic [`CP0_DATA_W-1:0]  causeOut,
    output logic [`CP0_DATA_W-1:0]  epcOut
);

    // write strobes
    logic countWr;
    logic compareWr;
    logic statusWr;
    logic causeWr;
    logic epcWr;

    // register values
    logic [`CP0_DATA_W-1:0] count;
    logic [`CP0_DATA_W-1:0] compare;
    logic [`CP0_DATA_W-1:0] status;
    logic [`CP0_DATA_W-1:0] cause;
    logic [`CP0_DATA_W-1:0] epc;
    logic [`CP0_DATA_W-1:0] badVAddr;
    logic                   timerIrq;

    cp0AccessPort i_accessPort (
        .wrEn, .wrAddr, .wrData, .rdAddr,
        .count, .compare, .status, .cause, .epc, .badVAddr,
        .countWr, .compareWr, .statusWr, .causeWr, .epcWr,
        .rdData,
        .statusFwd (statusOut),
        .causeFwd  (causeOut),
        .epcFwd    (epcOut)
    );

    cp0Timer i_timer (
        .clk, .rst, .countWr, .compareWr, .wrData,
        .count, .compare, .timerIrq
    );

    cp0ExceptionUnit i_exceptionUnit (
        .clk, .rst, .statusWr, .causeWr, .epcWr, .wrData,
        .hwInt, .timerIrq, .except, .pc, .aluOut, .inDelaySlot,
        .status, .cause, .epc, .badVAddr
    );

endmodule

//--- verif/cp0Checker.sv
// CP0 checker
// cycle model of the CP0 registers, compared with the DUT read port
// and forwarded views on every falling edge, with per-test counts

`include "cp0_config.svh"

module cp0Checker (
    input logic                    clk,
    input logic                    rst,
    input logic                    wrEn,
    input cp0Pkg::cp0RegAddrT      wrAddr,
    input logic [`CP0_DATA_W-1:0]  wrData,
    input cp0Pkg::cp0RegAddrT      rdAddr,
    input logic [`CP0_HWINT_N-1:0] hwInt,
    input cp0Pkg::exceptFlagsT     except,
    input logic [`CP0_DATA_W-1:0]  pc,
    input logic [`CP0_DATA_W-1:0]  aluOut,
    input logic                    inDelaySlot,
    input logic [`CP0_DATA_W-1:0]  rdData,
    input logic [`CP0_DATA_W-1:0]  statusOut,
    input logic [`CP0_DATA_W-1:0]  causeOut,
    input logic [`CP0_DATA_W-1:0]  epcOut
);
    timeunit 1ns;
    timeprecision 1ps;
    import cp0Pkg::*;

    typedef logic [`CP0_DATA_W-1:0] wordT;

    wordT  mCount, mCompare, mStatus, mCause, mEpc, mBad;   // mCause without TI
    logic  mPhase;
    logic  mIrq;
    logic  valid = 1'b0;
    string testName = "none";
    int    testErrs = 0;
    int    totalErrs = 0;
    int    testsRun = 0;
    int    testsFailed = 0;

    task automatic startTest(input string name);
        testName = name;
        testErrs = 0;
    endtask

    task automatic finishTest();
        testsRun++;
        if (testErrs != 0)
            testsFailed++;
        $display("test %s: %s, %0d errors", testName, (testErrs == 0) ? "ok" : "failed",
                 testErrs);
    endtask

    function automatic void compareWord(string sig, wordT expected, wordT actual);
        if (actual !== expected) begin
            $display("mismatch in test %s on %s: expected %h, actual %h", testName, sig,
                     expected, actual);
            testErrs++;
            totalErrs++;
        end
    endfunction

    function automatic wordT merge(wordT oldVal, wordT newVal, wordT mask);
        return (newVal & mask) | (oldVal & ~mask);
    endfunction

    // bit of the highest-priority flag, -1 when none is set
    function automatic int topFlag(exceptFlagsT f);
        for (int i = $bits(f) - 1; i >= 0; i--) begin
            if (f[i])
                return i;
        end
        return -1;
    endfunction

    function automatic logic [4:0] codeFor(int flag);
        case (flag)
            7, 0:    return excAdEL;
            6:       return excRI;
            5:       return excSys;
            4:       return excBp;
            2:       return excOv;
            1:       return excAdES;
            default: return excInt;
        endcase
    endfunction

    // ************************************************************
    // compare against the model, then advance it by one edge
    always @(negedge clk) begin
        wordT expStatus;
        wordT expCause;
        wordT expEpc;
        wordT expRd;
        logic [`CP0_HWINT_N-1:0] ipVec;
        logic wasExl;
        int   top;
        if (rst) begin
            mCount   = '0;
            mCompare = '0;
            mStatus  = `CP0_STATUS_RESET;
            mCause   = '0;
            mEpc     = '0;
            mBad     = '0;
            mPhase   = 1'b0;
            mIrq     = 1'b0;
            valid    = 1'b1;
        end else if (valid) begin
            expStatus = (wrEn && wrAddr == regStatus) ?
                merge(mStatus, wrData, `CP0_STATUS_WMASK) : mStatus;
            expCause = (wrEn && wrAddr == regCause) ?
                merge(mCause, wrData, `CP0_CAUSE_WMASK) : mCause;
            expEpc = (wrEn && wrAddr == regEpc) ? wrData : mEpc;
            case (rdAddr)
                regCount:    expRd = (wrEn && wrAddr == regCount) ? wrData : mCount;
                regCompare:  expRd = (wrEn && wrAddr == regCompare) ? wrData : mCompare;
                regStatus:   expRd = expStatus;
                regCause:    expRd = expCause;
                regEpc:      expRd = expEpc;
                regBadVAddr: expRd = mBad;
                default:     expRd = '0;
            endcase
            if (rdAddr == regCause)
                expRd[`CP0_CAUSE_TI] = mIrq;
            mCause = expCause;                  // stored part, TI stays live
            expCause[`CP0_CAUSE_TI] = mIrq;
            compareWord("rdData", expRd, rdData);
            compareWord("statusOut", expStatus, statusOut);
            compareWord("causeOut", expCause, causeOut);
            compareWord("epcOut", expEpc, epcOut);

            // timer
            ipVec = hwInt;
            ipVec[`CP0_HWINT_N-1] = hwInt[`CP0_HWINT_N-1] | mIrq;
            if (wrEn && wrAddr == regCompare) begin
                mIrq     = 1'b0;
                mCompare = wrData;
            end else if (mCompare != '0 && mCount == mCompare) begin
                mIrq = 1'b1;
            end
            if (wrEn && wrAddr == regCount) begin
                mCount = wrData;
                mPhase = 1'b0;
            end else begin
                if (mPhase)
                    mCount = mCount + 1'b1;
                mPhase = !mPhase;
            end

            // registers, exception entry after the writes
            wasExl  = mStatus[`CP0_STATUS_EXL];
            mStatus = expStatus;
            mEpc    = expEpc;
            mCause[`CP0_CAUSE_IP_LO +: `CP0_HWINT_N] = ipVec;
            top = topFlag(except);
            if (top == 3) begin                 // eret
                mStatus[`CP0_STATUS_EXL] = 1'b0;
            end else if (top >= 0) begin
                mStatus[`CP0_STATUS_EXL] = 1'b1;
                mCause[`CP0_CAUSE_EXC_LO +: 5] = codeFor(top);
                if (!wasExl) begin
                    mEpc = inDelaySlot ? pc - 32'd4 : pc;
                    mCause[`CP0_CAUSE_BD] = inDelaySlot;
                end
                if (top == 7)
                    mBad = pc;
                else if (top <= 1)
                    mBad = aluOut;
            end
        end
    end

endmodule

//--- verif/cp0ClockGen.sv
// CP0 testbench clock and reset
// 100 ns clock, reset held high for the first five cycles

module cp0ClockGen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;        // released on the fifth edge
    end

endmodule

//--- verif/cp0Tb.sv
// CP0 testbench top
// drives reset reads, masked writes, timer, exception and interrupt
// stimulus into the CP0 block from a fixed seed, with a watchdog

`include "cp0_config.svh"

module cp0Tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cp0Pkg::*;

    localparam int RESET_CYCLES = 5;
    localparam int READ_CYCLES  = 32;
    localparam int WRITE_CYCLES = 80;
    localparam int COUNT_CYCLES = 42;
    localparam int TIMER_CYCLES = 23;
    localparam int EXC_CYCLES   = 120;
    localparam int IRQ_CYCLES   = 30;
    localparam int GAP_CYCLES   = 2;        // idle and report cycles per test
    localparam int ALL_CYCLES   = RESET_CYCLES + READ_CYCLES + WRITE_CYCLES + COUNT_CYCLES
        + TIMER_CYCLES + EXC_CYCLES + IRQ_CYCLES + 6 * GAP_CYCLES;
    localparam int LIMIT_NS     = ALL_CYCLES * 100 * 12 / 10;

    typedef logic [`CP0_HWINT_N-1:0] hwIntT;

    logic                    clk;
    logic                    rst;
    logic                    wrEn;
    cp0RegAddrT              wrAddr;
    logic [`CP0_DATA_W-1:0]  wrData;
    cp0RegAddrT              rdAddr;
    logic [`CP0_DATA_W-1:0]  rdData;
    logic [`CP0_HWINT_N-1:0] hwInt;
    exceptFlagsT             except;
    logic [`CP0_DATA_W-1:0]  pc;
    logic [`CP0_DATA_W-1:0]  aluOut;
    logic                    inDelaySlot;
    logic [`CP0_DATA_W-1:0]  statusOut;
    logic [`CP0_DATA_W-1:0]  causeOut;
    logic [`CP0_DATA_W-1:0]  epcOut;

    cp0RegAddrT regList [6] = '{regBadVAddr, regCount, regCompare, regStatus, regCause, regEpc};

    cp0ClockGen i_clockGen (.clk, .rst);
    cp0Top      i_cp0Top (.*);
    cp0Checker  i_checker (.*);

    task automatic driveCycle(input logic we, input cp0RegAddrT wa,
                              input logic [`CP0_DATA_W-1:0] wd, input cp0RegAddrT ra);
        @(posedge clk);
        wrEn   <= we;
        wrAddr <= wa;
        wrData <= wd;
        rdAddr <= ra;
    endtask

    // idle cycle, then report once the last cycle was checked
    task automatic closeTest();
        @(posedge clk);
        wrEn   <= 1'b0;
        except <= '0;
        hwInt  <= '0;
        @(posedge clk);
        i_checker.finishTest();
    endtask

    initial begin
        #(LIMIT_NS);
        $display("timeout: the tests did not finish within %0d ns", LIMIT_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [8:0] flags;
        logic [`CP0_DATA_W-1:0] start;
        cp0RegAddrT ra;
        int assertFails;
        void'($urandom(32'h324bc4db));
        wrEn        = 1'b0;
        wrAddr      = regStatus;
        wrData      = '0;
        rdAddr      = regStatus;
        hwInt       = '0;
        except      = '0;
        pc          = '0;
        aluOut      = '0;
        inDelaySlot = 1'b0;
        wait (!rst);

        i_checker.startTest("reset");
        for (int a = 0; a < READ_CYCLES; a++)
            driveCycle(1'b0, regStatus, '0, cp0RegAddrT'(a[4:0]));
        closeTest();

        i_checker.startTest("masked writes");
        for (int n = 0; n < WRITE_CYCLES / 2; n++) begin
            ra = regList[$urandom_range(5)];
            driveCycle(1'b1, ra, $urandom, ra);     // same-cycle forward
            driveCycle(1'b0, ra, '0, ra);
        end
        closeTest();

        i_checker.startTest("count");
        repeat (2) begin
            driveCycle(1'b1, regCount, $urandom, regCount);
            repeat (COUNT_CYCLES / 2 - 1) driveCycle(1'b0, regCount, '0, regCount);
        end
        closeTest();

        // Compare a few counts ahead, then acknowledged by a write
        i_checker.startTest("timer interrupt");
        start = $urandom & 32'h0fff_ffff;
        driveCycle(1'b1, regCount, start, regCause);
        driveCycle(1'b1, regCompare, start + 32'd5, regCause);
        repeat (16) driveCycle(1'b0, regCause, '0, regCause);
        driveCycle(1'b1, regCompare, '0, regCause);
        repeat (4) driveCycle(1'b0, regCause, '0, regCause);
        closeTest();

        i_checker.startTest("exceptions");
        for (int n = 0; n < EXC_CYCLES / 2; n++) begin
            flags = 9'd1 << $urandom_range(8);
            if ($urandom_range(3) == 0)
                flags = flags | (9'd1 << $urandom_range(8));
            if ($urandom_range(3) == 0)
                flags = 9'b0_0000_1000;             // eret alone
            @(posedge clk);
            except      <= flags;
            pc          <= $urandom;
            aluOut      <= $urandom;
            inDelaySlot <= ($urandom_range(1) == 1);
            wrEn        <= ($urandom_range(3) == 0);
            wrAddr      <= regList[$urandom_range(5)];
            wrData      <= $urandom;
            rdAddr      <= $urandom_range(1) ? regBadVAddr : regCause;
            @(posedge clk);
            except <= '0;
            wrEn   <= 1'b0;
        end
        closeTest();

        i_checker.startTest("interrupt sampling");
        repeat (IRQ_CYCLES) begin
            @(posedge clk);
            hwInt  <= hwIntT'($urandom);
            rdAddr <= regCause;
        end
        closeTest();

        assertFails = i_cp0Top.i_assert.failCount;
        $display("summary: %0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 i_checker.testsRun, i_checker.testsFailed, i_checker.totalErrs, assertFails);
        if (i_checker.testsFailed == 0 && assertFails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verif/cp0_assert.sv
// CP0 assertions
// timer interrupt clearing, EXL on exception entry and a defined
// read port, bound into the CP0 top level

`include "cp0_config.svh"

module cp0Assert (
    input logic                   clk,
    input logic                   rst,
    input logic                   compareWr,
    input logic                   timerIrq,
    input logic [`CP0_DATA_W-1:0] status,
    input cp0Pkg::exceptFlagsT    except,
    input logic [`CP0_DATA_W-1:0] rdData
);
    timeunit 1ns;
    timeprecision 1ps;

    int   failCount = 0;
    logic excTaken;

    // eret only blocks entry when no higher flag is set
    assign excTaken = except.interrupt || except.fetchAddrErr || except.reservedInstr
        || except.syscall || except.breakpoint
        || (!except.eret && (except.overflow || except.storeAddrErr || except.loadAddrErr));

    irqFall: assert property (@(posedge clk) $fell(timerIrq) |-> ($past(compareWr) || $past(rst)))
        else begin
            failCount++;
            $error("timer interrupt dropped without a Compare write or reset");
        end

    exlSet: assert property (@(posedge clk) disable iff (rst)
        excTaken |=> status[`CP0_STATUS_EXL])
        else begin
            failCount++;
            $error("EXL not set after exception entry");
        end

    rdKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(rdData))
        else begin
            failCount++;
            $error("read data has unknown bits");
        end

endmodule

bind cp0Top cp0Assert i_assert (
    .clk       (clk),
    .rst       (rst),
    .compareWr (compareWr),
    .timerIrq  (timerIrq),
    .status    (status),
    .except    (except),
    .rdData    (rdData)
);
